/* flist.f */
rtl/bs_pkg.sv
rtl/bs_req_fifo.sv
rtl/bs_pop_sel.sv
rtl/cntr_bs_dp.sv
sim/bs_assert.sv
sim/tb_cntr_bs_dp.sv

/* rtl/bs_pkg.sv */
package bs_pkg;

   // ********************
   // Request field widths
   // ********************
   localparam int BS_RA  = 16;                   // Row address
   localparam int BS_CA  = 10;                   // Column address
   localparam int BS_DQ  = 16;                   // Write data
   localparam int BS_IDX = 7;                    // Request index

   // ********************
   // Queue organisation
   // ********************
   localparam int BS_RD_NUM   = 4;               // Read queues, bits 0..3
   localparam int BS_WR_NUM   = 3;               // Write queues, bits 4..6
   localparam int BS_FIFO_NUM = BS_RD_NUM + BS_WR_NUM;
   localparam int BS_WR_BASE  = BS_RD_NUM;       // First write queue bit

   localparam int BS_RD_DEPTH = 4;               // Entries per read queue
   localparam int BS_WR_DEPTH = 2;               // Entries per write queue

   localparam int BS_LAST_RA_W = BS_FIFO_NUM * BS_RA;  // Packed tail rows, queue 0 low

   // ********************
   // Stored payloads
   // ********************
   // Read entry, 33 bits
   typedef struct packed {
      logic [BS_IDX-1:0] idx;                    // Request index
      logic [BS_RA-1:0]  ra;                     // Row, used for row hit search
      logic [BS_CA-1:0]  ca;                     // Column
   } bs_rd_req_t;

   // Write entry, 49 bits
   typedef struct packed {
      logic [BS_IDX-1:0] idx;                    // Request index
      logic [BS_DQ-1:0]  dq;                     // Write data
      logic [BS_RA-1:0]  ra;                     // Row, same name as read entry
      logic [BS_CA-1:0]  ca;                     // Column
   } bs_wr_req_t;

endpackage

/* rtl/bs_pop_sel.sv */
`timescale 1ns/10ps

module bs_pop_sel (
   input  logic [bs_pkg::BS_FIFO_NUM-1:0] pop_i,        // One-hot queue select
   input  logic [bs_pkg::BS_FIFO_NUM-1:0] fifo_valid_i, // Queue not empty
   input  bs_pkg::bs_rd_req_t             rd_head_i [bs_pkg::BS_RD_NUM],
   input  bs_pkg::bs_wr_req_t             wr_head_i [bs_pkg::BS_WR_NUM],
   output logic [bs_pkg::BS_FIFO_NUM-1:0] deq_o,        // Per-queue dequeue strobe
   output logic                           grant_o,      // Pop accepted
   output logic [bs_pkg::BS_DQ-1:0]       dq_o,
   output logic [bs_pkg::BS_IDX-1:0]      idx_o,
   output logic [bs_pkg::BS_RA-1:0]       ra_o,
   output logic [bs_pkg::BS_CA-1:0]       ca_o
);

   import bs_pkg::*;

   logic                   pop_one_hot;          // Exactly one bit set
   logic [BS_FIFO_NUM-1:0] deq;                  // Granted queue, at most one bit

   // ********************
   // Grant
   // ********************
   assign pop_one_hot = $onehot(pop_i);
   assign deq         = pop_one_hot ? (pop_i & fifo_valid_i) : '0;  // Empty queue gets nothing
   assign deq_o       = deq;
   assign grant_o     = |deq;

   // ********************
   // Head select
   // ********************
   // deq has at most one bit, so the loops never overlap
   always_comb begin
      dq_o  = '0;                                // Zero unless a write queue wins
      idx_o = '0;
      ra_o  = '0;
      ca_o  = '0;

      for (int i = 0; i < BS_RD_NUM; i++) begin
         if (deq[i]) begin                       // Read queue, no data
            idx_o = rd_head_i[i].idx;
            ra_o  = rd_head_i[i].ra;
            ca_o  = rd_head_i[i].ca;
         end
      end

      for (int j = 0; j < BS_WR_NUM; j++) begin
         if (deq[BS_WR_BASE + j]) begin          // Write queue, full entry
            dq_o  = wr_head_i[j].dq;
            idx_o = wr_head_i[j].idx;
            ra_o  = wr_head_i[j].ra;
            ca_o  = wr_head_i[j].ca;
         end
      end
   end

endmodule

/* rtl/bs_req_fifo.sv */
`timescale 1ns/10ps

module bs_req_fifo #(
   parameter type         T     = bs_pkg::bs_rd_req_t,  // Payload, needs an ra field
   parameter int unsigned DEPTH = bs_pkg::BS_RD_DEPTH   // Number of entries
) (
   input  logic                     clk,
   input  logic                     arst_n_i,
   input  logic                     push_i,     // Enqueue strobe
   input  logic                     pop_i,      // Dequeue strobe
   input  T                         data_i,     // Entry to store
   output T                         head_o,     // Oldest entry, show-ahead
   output logic                     valid_o,    // Not empty
   output logic                     full_o,     // DEPTH entries held
   output logic                     mid_o,      // At least half full
   output logic [bs_pkg::BS_RA-1:0] tail_ra_o   // Row of last accepted push
);

   import bs_pkg::*;

   // ********************
   // Sizing
   // ********************
   localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W   = $clog2(DEPTH + 1);
   localparam int MID_LVL = (DEPTH + 1) / 2;    // Half of DEPTH, rounded up

   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);
   localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(MID_LVL);

   T                 mem [DEPTH];               // Entry storage
   logic [PTR_W-1:0] wr_ptr;                    // Next slot to write
   logic [PTR_W-1:0] rd_ptr;                    // Current head slot
   logic [CNT_W-1:0] cnt;                       // Occupancy
   logic [BS_RA-1:0] tail_ra_q;                 // Last accepted row
   logic             push_ok;                   // Push taken this edge
   logic             pop_ok;                    // Pop taken this edge

   // Both decisions use the count before the edge,
   // so a push into a full queue is lost even if it pops now
   assign push_ok = push_i && !full_o;
   assign pop_ok  = pop_i && valid_o;

   // ********************
   // Pointers and count
   // ********************
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (push_ok) begin
            if (wr_ptr == PTR_LAST) begin       // Wrap, DEPTH may not be a power of 2
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (pop_ok) begin
            if (rd_ptr == PTR_LAST) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         case ({push_ok, pop_ok})
            2'b10:   cnt <= cnt + 1'b1;         // Fill
            2'b01:   cnt <= cnt - 1'b1;         // Drain
            default: cnt <= cnt;                // Idle or both
         endcase
      end
   end

   // Storage write, payload only
   always_ff @(posedge clk) begin
      if (push_ok) begin
         mem[wr_ptr] <= data_i;
      end
   end

   // Tail row for the row hit search
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tail_ra_q <= '0;
      end else if (push_ok) begin
         tail_ra_q <= data_i.ra;                // Held until next accepted push
      end
   end

   // ********************
   // Outputs
   // ********************
   assign head_o    = mem[rd_ptr];              // Stale when empty, masked by grant
   assign valid_o   = (cnt != '0);
   assign full_o    = (cnt == CNT_FULL);
   assign mid_o     = (cnt >= CNT_MID);
   assign tail_ra_o = tail_ra_q;

endmodule

/* rtl/cntr_bs_dp.sv */
`timescale 1ns/10ps

module cntr_bs_dp (
   input  logic                            clk,
   input  logic                            arst_n_i,
   input  logic                            valid_i,   // Request strobe from txn controller
   input  logic [bs_pkg::BS_FIFO_NUM-1:0]  push_i,    // One-hot target queue
   input  logic [bs_pkg::BS_FIFO_NUM-1:0]  pop_i,     // One-hot queue to drain
   input  logic [bs_pkg::BS_DQ-1:0]        dq_i,      // Write data
   input  logic [bs_pkg::BS_IDX-1:0]       idx_i,     // Request index
   input  logic [bs_pkg::BS_RA-1:0]        ra_i,      // Row address
   input  logic [bs_pkg::BS_CA-1:0]        ca_i,      // Column address
   output logic [bs_pkg::BS_FIFO_NUM-1:0]  full_o,
   output logic [bs_pkg::BS_FIFO_NUM-1:0]  mid_o,
   output logic [bs_pkg::BS_FIFO_NUM-1:0]  valid_o,
   output logic [bs_pkg::BS_LAST_RA_W-1:0] last_ra_o, // Queue 0 in low bits
   output logic                            grant_o,
   output logic [bs_pkg::BS_DQ-1:0]        dq_o,
   output logic [bs_pkg::BS_IDX-1:0]       idx_o,
   output logic [bs_pkg::BS_RA-1:0]        ra_o,
   output logic [bs_pkg::BS_CA-1:0]        ca_o
);

   import bs_pkg::*;

   // ********************
   // Internal signals
   // ********************
   bs_rd_req_t             rd_req;               // Incoming request as read entry
   bs_wr_req_t             wr_req;               // Incoming request as write entry
   logic [BS_FIFO_NUM-1:0] push_gated;           // Qualified push per queue
   logic [BS_FIFO_NUM-1:0] deq;                  // Pop strobes from selector
   logic [BS_FIFO_NUM-1:0] fifo_valid;
   logic [BS_FIFO_NUM-1:0] fifo_full;
   logic [BS_FIFO_NUM-1:0] fifo_mid;
   logic [BS_RA-1:0]       tail_ra [BS_FIFO_NUM];
   bs_rd_req_t             rd_head [BS_RD_NUM];
   bs_wr_req_t             wr_head [BS_WR_NUM];

   // Pack loose fields, reads drop dq_i
   assign rd_req.idx = idx_i;
   assign rd_req.ra  = ra_i;
   assign rd_req.ca  = ca_i;

   assign wr_req.idx = idx_i;
   assign wr_req.dq  = dq_i;
   assign wr_req.ra  = ra_i;
   assign wr_req.ca  = ca_i;

   // Zero or multi-hot push goes nowhere
   assign push_gated = (valid_i && $onehot(push_i)) ? push_i : '0;

   // ********************
   // Read queues
   // ********************
   for (genvar gr = 0; gr < BS_RD_NUM; gr++) begin : g_rd
      bs_req_fifo #(
         .T     (bs_rd_req_t),
         .DEPTH (BS_RD_DEPTH)
      ) u_rd_fifo (
         .clk       (clk),
         .arst_n_i  (arst_n_i),
         .push_i    (push_gated[gr]),
         .pop_i     (deq[gr]),
         .data_i    (rd_req),
         .head_o    (rd_head[gr]),
         .valid_o   (fifo_valid[gr]),
         .full_o    (fifo_full[gr]),
         .mid_o     (fifo_mid[gr]),
         .tail_ra_o (tail_ra[gr])
      );
   end

   // ********************
   // Write queues
   // ********************
   for (genvar gw = 0; gw < BS_WR_NUM; gw++) begin : g_wr
      bs_req_fifo #(
         .T     (bs_wr_req_t),
         .DEPTH (BS_WR_DEPTH)
      ) u_wr_fifo (
         .clk       (clk),
         .arst_n_i  (arst_n_i),
         .push_i    (push_gated[BS_WR_BASE + gw]),  // Bits above the read queues
         .pop_i     (deq[BS_WR_BASE + gw]),
         .data_i    (wr_req),
         .head_o    (wr_head[gw]),
         .valid_o   (fifo_valid[BS_WR_BASE + gw]),
         .full_o    (fifo_full[BS_WR_BASE + gw]),
         .mid_o     (fifo_mid[BS_WR_BASE + gw]),
         .tail_ra_o (tail_ra[BS_WR_BASE + gw])
      );
   end

   // ********************
   // Pop side
   // ********************
   bs_pop_sel u_pop_sel (
      .pop_i        (pop_i),
      .fifo_valid_i (fifo_valid),
      .rd_head_i    (rd_head),
      .wr_head_i    (wr_head),
      .deq_o        (deq),
      .grant_o      (grant_o),
      .dq_o         (dq_o),
      .idx_o        (idx_o),
      .ra_o         (ra_o),
      .ca_o         (ca_o)
   );

   // Flag vectors for the arbiter
   assign full_o  = fifo_full;
   assign mid_o   = fifo_mid;
   assign valid_o = fifo_valid;

   // Tail rows side by side, queue 0 lowest
   for (genvar gt = 0; gt < BS_FIFO_NUM; gt++) begin : g_last_ra
      assign last_ra_o[gt*BS_RA +: BS_RA] = tail_ra[gt];
   end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the bank scheduler datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_cntr_bs_dp \
   -Mdir obj_dir \
   -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_cntr_bs_dp 2>&1)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "ALL TESTS PASSED"; then
   exit 0
else
   echo "Pass message not found in simulation output"
   exit 1
fi

/* sim/bs_assert.sv */
`timescale 1ns/10ps

module bs_assert (
   input logic                            clk,
   input logic                            arst_n_i,
   input logic [bs_pkg::BS_FIFO_NUM-1:0]  full_i,        // Queue flags from the DUT
   input logic [bs_pkg::BS_FIFO_NUM-1:0]  mid_i,
   input logic [bs_pkg::BS_FIFO_NUM-1:0]  fifo_valid_i,
   input logic [bs_pkg::BS_FIFO_NUM-1:0]  pop_i,
   input logic                            grant_i,
   input logic [bs_pkg::BS_LAST_RA_W-1:0] last_ra_i
);

   import bs_pkg::*;

   localparam logic [BS_FIFO_NUM-1:0] NO_FLAGS = '0;

   // ********************
   // Flag consistency
   // ********************
   a_full_flags : assert property (@(posedge clk) disable iff (!arst_n_i)
      (full_i & ~(fifo_valid_i & mid_i)) == NO_FLAGS)
      else $error("Full queue without valid and mid");

   // ********************
   // Grant
   // ********************
   a_grant_one_hot : assert property (@(posedge clk) disable iff (!arst_n_i)
      grant_i |-> $onehot(pop_i))
      else $error("Grant with a pop vector that is not one-hot");

   a_grant_valid : assert property (@(posedge clk) disable iff (!arst_n_i)
      grant_i |-> (pop_i & fifo_valid_i) != NO_FLAGS)   // Granted queue holds data
      else $error("Grant on an empty queue");

   // Everything cleared while reset is held
   a_reset_quiet : assert property (@(posedge clk)
      !arst_n_i |-> (full_i == NO_FLAGS && mid_i == NO_FLAGS && fifo_valid_i == NO_FLAGS
                     && !grant_i && last_ra_i == '0))
      else $error("Flags not cleared during reset");

endmodule

bind cntr_bs_dp bs_assert u_bs_assert (
   .clk          (clk),
   .arst_n_i     (arst_n_i),
   .full_i       (full_o),
   .mid_i        (mid_o),
   .fifo_valid_i (valid_o),
   .pop_i        (pop_i),
   .grant_i      (grant_o),
   .last_ra_i    (last_ra_o)
);

/* sim/tb_cntr_bs_dp.sv */
`timescale 1ns/10ps

module tb_cntr_bs_dp;

   import bs_pkg::*;

   // ********************
   // Run length
   // ********************
   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DLY    = 2;                  // Input skew after rising edge
   localparam int RST_CYCLES   = 16;
   localparam int N_BAD_PUSH   = 40;                 // Dropped push patterns on empty queues
   localparam int FILL_TRIES   = 6;                  // Pushes per queue beyond any depth
   localparam int N_BAD_POP    = 20;                 // Zero or multi-hot pops on full queues
   localparam int N_MIXED      = 2000;
   localparam int TOTAL_CYCLES = RST_CYCLES + 1 + N_BAD_PUSH + 2 * BS_FIFO_NUM * FILL_TRIES
                                 + N_BAD_POP + N_MIXED;
   localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

   localparam logic [31:0] LFSR_SEED = 32'h301438f3;
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;    // x^32 + x^22 + x^2 + x + 1
   localparam int          ENT_W     = BS_IDX + BS_DQ + BS_RA + BS_CA;  // {idx, dq, ra, ca}

   logic                    clk;
   logic                    arst_n_i;
   logic                    valid_i;
   logic [BS_FIFO_NUM-1:0]  push_i;
   logic [BS_FIFO_NUM-1:0]  pop_i;
   logic [BS_DQ-1:0]        dq_i;
   logic [BS_IDX-1:0]       idx_i;
   logic [BS_RA-1:0]        ra_i;
   logic [BS_CA-1:0]        ca_i;
   logic [BS_FIFO_NUM-1:0]  full_o;
   logic [BS_FIFO_NUM-1:0]  mid_o;
   logic [BS_FIFO_NUM-1:0]  valid_o;
   logic [BS_LAST_RA_W-1:0] last_ra_o;
   logic                    grant_o;
   logic [BS_DQ-1:0]        dq_o;
   logic [BS_IDX-1:0]       idx_o;
   logic [BS_RA-1:0]        ra_o;
   logic [BS_CA-1:0]        ca_o;

   // Reference queues with the oldest entry at index 0
   logic [ENT_W-1:0] mdl_ent [BS_FIFO_NUM][BS_RD_DEPTH];  // Sized for the deepest queue
   int               mdl_cnt [BS_FIFO_NUM];
   logic [BS_RA-1:0] mdl_last_ra [BS_FIFO_NUM];
   logic [31:0]      lfsr_q;

   cntr_bs_dp dut (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .valid_i   (valid_i),
      .push_i    (push_i),
      .pop_i     (pop_i),
      .dq_i      (dq_i),
      .idx_i     (idx_i),
      .ra_i      (ra_i),
      .ca_i      (ca_i),
      .full_o    (full_o),
      .mid_o     (mid_o),
      .valid_o   (valid_o),
      .last_ra_o (last_ra_o),
      .grant_o   (grant_o),
      .dq_o      (dq_o),
      .idx_o     (idx_o),
      .ra_o      (ra_o),
      .ca_o      (ca_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ********************
   // Random source
   // ********************
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_TAPS;                // Feedback on shifted-out one
      end else begin
         return s >> 1;
      end
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r      = {r[30:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
      return r;
   endfunction

   function automatic logic [BS_FIFO_NUM-1:0] queue_bit(input int q);
      return BS_FIFO_NUM'(1) << q;
   endfunction

   function automatic logic [BS_FIFO_NUM-1:0] one_hot_rand();
      return queue_bit(int'(rand_bits(3)) % BS_FIFO_NUM);
   endfunction

   function automatic logic [BS_FIFO_NUM-1:0] multi_hot_rand();
      int a;
      int b;
      a = int'(rand_bits(3)) % BS_FIFO_NUM;
      b = (a + 1 + int'(rand_bits(3)) % (BS_FIFO_NUM - 1)) % BS_FIFO_NUM;  // Never a
      return queue_bit(a) | queue_bit(b);
   endfunction

   function automatic logic [BS_FIFO_NUM-1:0] rand_push();
      logic [31:0] r;
      r = rand_bits(4);
      if (r == 0) begin
         return '0;                                  // Rare empty push
      end else if (r == 1) begin
         return multi_hot_rand();
      end
      return one_hot_rand();
   endfunction

   function automatic logic [BS_FIFO_NUM-1:0] rand_pop();
      logic [31:0] r;
      r = rand_bits(3);
      if (r == 0) begin
         return multi_hot_rand();
      end else if (r < 4) begin
         return '0;                                  // Idle pop so queues fill up
      end
      return one_hot_rand();
   endfunction

   // ********************
   // Reference model
   // ********************
   function automatic int depth_of(input int q);
      return (q < BS_RD_NUM) ? BS_RD_DEPTH : BS_WR_DEPTH;
   endfunction

   // Index of the set bit or -1 unless exactly one bit is set
   function automatic int one_index(input logic [BS_FIFO_NUM-1:0] v);
      if ($countones(v) != 1) begin
         return -1;
      end
      for (int q = 0; q < BS_FIFO_NUM; q++) begin
         if (v == queue_bit(q)) begin
            return q;
         end
      end
      return -1;
   endfunction

   function automatic int granted_queue(input logic [BS_FIFO_NUM-1:0] pop);
      int q;
      q = one_index(pop);
      if (q >= 0 && mdl_cnt[q] > 0) begin
         return q;
      end
      return -1;                                     // Empty or not one-hot
   endfunction

   // Applied at the rising edge with both decisions on pre-edge counts
   function automatic void update_model();
      int               pq;
      int               sq;
      logic             push_ok;
      logic [BS_DQ-1:0] dq_val;
      pq      = granted_queue(pop_i);
      sq      = valid_i ? one_index(push_i) : -1;
      push_ok = (sq >= 0) && (mdl_cnt[sq] < depth_of(sq));   // Full queue drops it
      if (pq >= 0) begin
         for (int i = 0; i < BS_RD_DEPTH - 1; i++) begin
            mdl_ent[pq][i] = mdl_ent[pq][i + 1];
         end
         mdl_cnt[pq] = mdl_cnt[pq] - 1;
      end
      if (push_ok) begin
         dq_val = (sq >= BS_RD_NUM) ? dq_i : '0;     // Read queues keep no data
         mdl_ent[sq][mdl_cnt[sq]] = {idx_i, dq_val, ra_i, ca_i};
         mdl_cnt[sq]     = mdl_cnt[sq] + 1;
         mdl_last_ra[sq] = ra_i;
      end
   endfunction

   // ********************
   // Checking
   // ********************
   task automatic compare_value(input string what, input logic [127:0] exp,
                                input logic [127:0] act);
      if (exp !== act) begin
         $display("[FAIL] %0t: %s expected %0h, got %0h", $time, what, exp, act);
         $display("SOME TESTS FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic check_outputs();
      logic [BS_FIFO_NUM-1:0]  exp_full;
      logic [BS_FIFO_NUM-1:0]  exp_mid;
      logic [BS_FIFO_NUM-1:0]  exp_valid;
      logic [BS_LAST_RA_W-1:0] exp_last;
      logic [ENT_W-1:0]        head;
      int                      gq;
      exp_full  = '0;
      exp_mid   = '0;
      exp_valid = '0;
      exp_last  = '0;
      for (int q = 0; q < BS_FIFO_NUM; q++) begin
         if (mdl_cnt[q] == depth_of(q)) begin
            exp_full = exp_full | queue_bit(q);
         end
         if (2 * mdl_cnt[q] >= depth_of(q)) begin
            exp_mid = exp_mid | queue_bit(q);
         end
         if (mdl_cnt[q] > 0) begin
            exp_valid = exp_valid | queue_bit(q);
         end
         exp_last = exp_last | (BS_LAST_RA_W'(mdl_last_ra[q]) << (q * BS_RA));
      end
      gq   = granted_queue(pop_i);
      head = (gq >= 0) ? mdl_ent[gq][0] : '0;       // Zero outputs without grant
      compare_value("full_o", 128'(exp_full), 128'(full_o));
      compare_value("mid_o", 128'(exp_mid), 128'(mid_o));
      compare_value("valid_o", 128'(exp_valid), 128'(valid_o));
      compare_value("last_ra_o", 128'(exp_last), 128'(last_ra_o));
      compare_value("grant_o", 128'(gq >= 0), 128'(grant_o));
      compare_value("idx_o", 128'(head[BS_CA + BS_RA + BS_DQ +: BS_IDX]), 128'(idx_o));
      compare_value("dq_o", 128'(head[BS_CA + BS_RA +: BS_DQ]), 128'(dq_o));
      compare_value("ra_o", 128'(head[BS_CA +: BS_RA]), 128'(ra_o));
      compare_value("ca_o", 128'(head[0 +: BS_CA]), 128'(ca_o));
   endtask

   // One clock of driving and a mid-cycle check before the model steps at the edge
   task automatic drive_cycle(input logic v, input logic [BS_FIFO_NUM-1:0] push,
                              input logic [BS_FIFO_NUM-1:0] pop);
      #(DRIVE_DLY);
      valid_i = v;
      push_i  = push;
      pop_i   = pop;
      dq_i    = BS_DQ'(rand_bits(BS_DQ));
      idx_i   = BS_IDX'(rand_bits(BS_IDX));
      ra_i    = BS_RA'(rand_bits(BS_RA));
      ca_i    = BS_CA'(rand_bits(BS_CA));
      @(negedge clk);
      check_outputs();
      @(posedge clk);
      update_model();
   endtask

   // ********************
   // Watchdog
   // ********************
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired: run did not finish within %0d ns", WATCHDOG_NS);
      $display("SOME TESTS FAILED");
      $fatal(1, "Timeout");
   end

   // ********************
   // Stimulus
   // ********************
   initial begin
      logic [31:0] sel;
      clk      = 1'b0;
      arst_n_i = 1'b1;
      valid_i  = 1'b0;
      push_i   = '0;
      pop_i    = '0;
      dq_i     = '0;
      idx_i    = '0;
      ra_i     = '0;
      ca_i     = '0;
      lfsr_q   = LFSR_SEED;
      for (int q = 0; q < BS_FIFO_NUM; q++) begin
         mdl_cnt[q]     = 0;
         mdl_last_ra[q] = '0;
         for (int i = 0; i < BS_RD_DEPTH; i++) begin
            mdl_ent[q][i] = '0;
         end
      end
      #1 arst_n_i = 1'b0;                            // Real falling edge for async reset
      repeat (RST_CYCLES) @(posedge clk);
      #(DRIVE_DLY) arst_n_i = 1'b1;
      @(negedge clk);
      check_outputs();                               // All quiet after reset
      @(posedge clk);
      update_model();

      repeat (N_BAD_PUSH) begin                      // Nothing here may land
         sel = rand_bits(2);
         if (sel == 0) begin
            drive_cycle(1'b0, one_hot_rand(), '0);   // Strobe low
         end else if (sel == 1) begin
            drive_cycle(1'b1, '0, '0);
         end else begin
            drive_cycle(1'b1, multi_hot_rand(), '0);
         end
      end

      for (int q = 0; q < BS_FIFO_NUM; q++) begin    // Fill past full
         repeat (FILL_TRIES) drive_cycle(1'b1, queue_bit(q), '0);
      end

      repeat (N_BAD_POP) begin
         sel = rand_bits(1);
         drive_cycle(1'b0, '0, (sel == 0) ? '0 : multi_hot_rand());
      end

      for (int q = 0; q < BS_FIFO_NUM; q++) begin    // Drain and then pop empty queues
         repeat (FILL_TRIES) drive_cycle(1'b0, '0, queue_bit(q));
      end

      repeat (N_MIXED) begin
         sel = rand_bits(2);
         drive_cycle(sel != 0, rand_push(), rand_pop());
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule
